/* verilog/controlPkg.sv */
`default_nettype none

package controlPkg;

  // Instruction fields
  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;

  // Datapath select widths
  typedef logic [2:0] aluOpT;
  typedef logic [1:0] aluSrcBT;
  typedef logic [2:0] regDstT;
  typedef logic [3:0] memToRegT;
  typedef logic [2:0] iOrDT;
  typedef logic [1:0] pcSourceT;

  // ALU operations
  localparam aluOpT aluPass = 3'b000;
  localparam aluOpT aluAdd  = 3'b001;
  localparam aluOpT aluSub  = 3'b010;
  localparam aluOpT aluAnd  = 3'b011;
  localparam aluOpT aluSlt  = 3'b111;

  localparam aluSrcBT srcBReg  = 2'b00;
  localparam aluSrcBT srcBFour = 2'b01;
  localparam aluSrcBT srcBImm  = 2'b10;

  localparam regDstT dstRt = 3'b000;
  localparam regDstT dstRd = 3'b001;
  localparam regDstT dstRa = 3'b010;

  // Write-back source, 1010 picks the ALU less-than flag
  localparam memToRegT wbAluOut   = 4'b0000;
  localparam memToRegT wbLessThan = 4'b1010;

  localparam iOrDT addrZero   = 3'b000;
  localparam iOrDT addrPc     = 3'b011;
  localparam iOrDT addrAluOut = 3'b100;

  localparam pcSourceT pcAlu    = 2'b00;
  localparam pcSourceT pcJump   = 2'b01;
  localparam pcSourceT pcVector = 2'b10;
  localparam pcSourceT pcEpc    = 2'b11;

  // Opcodes
  localparam opcodeT opcodeRType = 6'b000000;
  localparam opcodeT opcodeAddiu = 6'b001001;
  localparam opcodeT opcodeSlti  = 6'b001010;
  localparam opcodeT opcodeSw    = 6'b101011;
  localparam opcodeT opcodeJal   = 6'b000011;

  // R-type functs
  localparam functT functAdd   = 6'b100000;
  localparam functT functSub   = 6'b100010;
  localparam functT functAnd   = 6'b100100;
  localparam functT functSlt   = 6'b101010;
  localparam functT functJr    = 6'b001000;
  localparam functT functBreak = 6'b001101;
  localparam functT functRte   = 6'b010011;

  // Memory latency seen by fetch
  localparam int fetchWaitDefault = 2;

  typedef enum logic [3:0] {
    kindAdd, kindSub, kindAnd, kindSlt, kindJr, kindBreak, kindRte,
    kindAddiu, kindSlti, kindSw, kindJal, kindInvalid
  } instrKindT;

  // Execute states sit after stDecode, stException last
  typedef enum logic [4:0] {
    stReset,
    stFetchWait, stFetchPc, stFetchIr,
    stDecode,
    stAdd, stSub, stAnd, stSlt, stJr, stBreak, stRte,
    stAddiu, stSlti, stSw, stJal,
    stException
  } ctrlStateT;

endpackage

`default_nettype wire

/* verilog/instrDecoder.sv */
`default_nettype none

module instrDecoder (
  input  wire controlPkg::opcodeT opcode,
  input  wire controlPkg::functT  funct,
  output controlPkg::instrKindT   instrKind
);

  import controlPkg::*;

  instrKindT rKind;

  // Funct decode, only meaningful under the R-type opcode
  always_comb begin
    case (funct)
      functAdd: begin
        rKind = kindAdd;
      end
      functSub: begin
        rKind = kindSub;
      end
      functAnd: begin
        rKind = kindAnd;
      end
      functSlt: begin
        rKind = kindSlt;
      end
      functJr: begin
        rKind = kindJr;
      end
      functBreak: begin
        rKind = kindBreak;
      end
      functRte: begin
        rKind = kindRte;
      end
      default: begin
        rKind = kindInvalid;
      end
    endcase
  end

  always_comb begin
    case (opcode)
      opcodeRType: begin
        instrKind = rKind;
      end
      opcodeAddiu: begin
        instrKind = kindAddiu;
      end
      opcodeSlti: begin
        instrKind = kindSlti;
      end
      opcodeSw: begin
        instrKind = kindSw;
      end
      opcodeJal: begin
        instrKind = kindJal;
      end
      default: begin
        instrKind = kindInvalid;
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/controlFsm.sv */
`default_nettype none

module controlFsm #(
  parameter int FetchWait = controlPkg::fetchWaitDefault
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire controlPkg::instrKindT instrKind,
  output controlPkg::ctrlStateT   state
);

  import controlPkg::*;

  localparam int countWidth = (FetchWait > 1) ? $clog2(FetchWait) : 1;
  localparam logic [countWidth-1:0] lastCount = countWidth'(FetchWait - 1);

  ctrlStateT             nextState;
  logic [countWidth-1:0] fetchCount;
  // Set while reset is high, keeps stReset one extra cycle
  logic                  resetHold;

  always_comb begin
    nextState = state;
    case (state)
      stReset: begin
        nextState = resetHold ? stReset : stFetchWait;
      end
      stFetchWait: begin
        if (fetchCount == lastCount) begin
          nextState = stFetchPc;
        end
      end
      stFetchPc: begin
        nextState = stFetchIr;
      end
      stFetchIr: begin
        nextState = stDecode;
      end
      stDecode: begin
        case (instrKind)
          kindAdd:   nextState = stAdd;
          kindSub:   nextState = stSub;
          kindAnd:   nextState = stAnd;
          kindSlt:   nextState = stSlt;
          kindJr:    nextState = stJr;
          kindBreak: nextState = stBreak;
          kindRte:   nextState = stRte;
          kindAddiu: nextState = stAddiu;
          kindSlti:  nextState = stSlti;
          kindSw:    nextState = stSw;
          kindJal:   nextState = stJal;
          default:   nextState = stException;
        endcase
      end
      // Execute states and the trap all take one cycle
      default: begin
        nextState = stFetchWait;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= stReset;
      resetHold  <= 1'b1;
      fetchCount <= '0;
    end else begin
      state     <= nextState;
      resetHold <= 1'b0;
      if (state == stFetchWait && fetchCount != lastCount) begin
        fetchCount <= fetchCount + 1'b1;
      end else begin
        fetchCount <= '0;
      end
    end
  end

  stateLegal: assert property (@(posedge clk) disable iff (reset)
    state inside {[stReset:stException]})
    else $error("FSM state %0d outside the state set", state);

  // A new fetch only follows reset or a finished instruction
  fetchEntry: assert property (@(posedge clk) disable iff (reset)
    (state == stFetchWait && $past(state) != stFetchWait)
      |-> $past(state) inside {stReset, [stAdd:stException]})
    else $error("stFetchWait entered from state %0d", $past(state));

endmodule

`default_nettype wire

/* verilog/controlWordGen.sv */
`default_nettype none

module controlWordGen (
  input  wire controlPkg::ctrlStateT state,
  output logic                   pcWrite,
  output logic                   aWrite,
  output logic                   bWrite,
  output logic                   epcWrite,
  output logic                   irWrite,
  output logic                   regWrite,
  output logic                   memWrite,
  output logic                   aluSrcA,
  output logic                   resetOut,
  output controlPkg::aluOpT      aluOp,
  output controlPkg::aluSrcBT    aluSrcB,
  output controlPkg::regDstT     regDst,
  output controlPkg::memToRegT   memToReg,
  output controlPkg::iOrDT       iOrD,
  output controlPkg::pcSourceT   pcSource
);

  import controlPkg::*;

  always_comb begin
    pcWrite  = 1'b0;
    aWrite   = 1'b0;
    bWrite   = 1'b0;
    epcWrite = 1'b0;
    irWrite  = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    aluSrcA  = 1'b0;
    resetOut = 1'b0;
    aluOp    = aluPass;
    aluSrcB  = srcBReg;
    regDst   = dstRt;
    memToReg = wbAluOut;
    iOrD     = addrZero;
    pcSource = pcAlu;

    case (state)
      stReset: begin
        resetOut = 1'b1;
      end
      stFetchWait: begin
        iOrD = addrPc;
      end
      // PC + 4 while the instruction word settles
      stFetchPc: begin
        pcWrite = 1'b1;
        aluOp   = aluAdd;
        aluSrcB = srcBFour;
      end
      stFetchIr: begin
        irWrite = 1'b1;
      end
      stDecode: begin
        aWrite = 1'b1;
        bWrite = 1'b1;
      end
      stAdd, stSub, stAnd, stSlt: begin
        regWrite = 1'b1;
        aluSrcA  = 1'b1;
        aluSrcB  = srcBReg;
        regDst   = dstRd;
        case (state)
          stAdd:   aluOp = aluAdd;
          stSub:   aluOp = aluSub;
          stAnd:   aluOp = aluAnd;
          default: aluOp = aluSlt;
        endcase
        memToReg = (state == stSlt) ? wbLessThan : wbAluOut;
      end
      stAddiu, stSlti: begin
        regWrite = 1'b1;
        aluSrcA  = 1'b1;
        aluSrcB  = srcBImm;
        regDst   = dstRt;
        aluOp    = (state == stSlti) ? aluSlt : aluAdd;
        memToReg = (state == stSlti) ? wbLessThan : wbAluOut;
      end
      stSw: begin
        memWrite = 1'b1;
        aluOp    = aluAdd;
        aluSrcA  = 1'b1;
        aluSrcB  = srcBImm;
        iOrD     = addrAluOut;
      end
      // Register A passes straight to the PC
      stJr: begin
        pcWrite  = 1'b1;
        aluOp    = aluPass;
        aluSrcA  = 1'b1;
        pcSource = pcAlu;
      end
      stJal: begin
        pcWrite  = 1'b1;
        regWrite = 1'b1;
        regDst   = dstRa;
        pcSource = pcJump;
      end
      // Undo the fetch increment
      stBreak: begin
        pcWrite  = 1'b1;
        aluOp    = aluSub;
        aluSrcB  = srcBFour;
        pcSource = pcAlu;
      end
      stRte: begin
        pcWrite  = 1'b1;
        pcSource = pcEpc;
      end
      stException: begin
        epcWrite = 1'b1;
        pcWrite  = 1'b1;
        pcSource = pcVector;
      end
      default: begin
        resetOut = 1'b0;
      end
    endcase
  end

  always_comb begin
    assert final (!(regWrite && memWrite))
      else $error("regWrite and memWrite both high in state %0d", state);
    assert final (!(irWrite && pcWrite))
      else $error("irWrite and pcWrite both high in state %0d", state);
  end

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
`default_nettype none

module controlUnit #(
  parameter int FetchWait = controlPkg::fetchWaitDefault
) (
  input  wire                        clk,
  input  wire                        reset,
  input  wire controlPkg::opcodeT    opcode,
  input  wire controlPkg::functT     funct,
  output wire                        pcWrite,
  output wire                        aWrite,
  output wire                        bWrite,
  output wire                        epcWrite,
  output wire                        irWrite,
  output wire                        regWrite,
  output wire                        memWrite,
  output wire                        aluSrcA,
  output wire                        resetOut,
  output wire controlPkg::aluOpT     aluOp,
  output wire controlPkg::aluSrcBT   aluSrcB,
  output wire controlPkg::regDstT    regDst,
  output wire controlPkg::memToRegT  memToReg,
  output wire controlPkg::iOrDT      iOrD,
  output wire controlPkg::pcSourceT  pcSource
);

  import controlPkg::*;

  instrKindT instrKind;
  ctrlStateT state;

  instrDecoder u_instrDecoder (
    .opcode    (opcode),
    .funct     (funct),
    .instrKind (instrKind)
  );

  controlFsm #(
    .FetchWait (FetchWait)
  ) u_controlFsm (
    .clk       (clk),
    .reset     (reset),
    .instrKind (instrKind),
    .state     (state)
  );

  // All datapath controls come from the current state only
  controlWordGen u_controlWordGen (
    .state    (state),
    .pcWrite  (pcWrite),
    .aWrite   (aWrite),
    .bWrite   (bWrite),
    .epcWrite (epcWrite),
    .irWrite  (irWrite),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .aluSrcA  (aluSrcA),
    .resetOut (resetOut),
    .aluOp    (aluOp),
    .aluSrcB  (aluSrcB),
    .regDst   (regDst),
    .memToReg (memToReg),
    .iOrD     (iOrD),
    .pcSource (pcSource)
  );

endmodule

`default_nettype wire

/* testbench/tbClock.sv */
`default_nettype none

module tbClock #(
  parameter int HalfPeriod = 2
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
  end

  // 4 ns period
  always #(HalfPeriod) clk = ~clk;

endmodule

`default_nettype wire

/* testbench/controlChecks.svh */
`ifndef CONTROL_CHECKS_SVH
`define CONTROL_CHECKS_SVH

task automatic compareValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
  checkCount++;
  if (actual !== expected) begin
    errorCount++;
    $display("Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
  end
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
  compareValue(name, 32'(expected), 32'(actual));
endtask

task automatic checkAluOp(input string name, input aluOpT expected, input aluOpT actual);
  compareValue(name, 32'(expected), 32'(actual));
endtask

task automatic checkAluSrcB(input string name, input aluSrcBT expected, input aluSrcBT actual);
  compareValue(name, 32'(expected), 32'(actual));
endtask

task automatic checkRegDst(input string name, input regDstT expected, input regDstT actual);
  compareValue(name, 32'(expected), 32'(actual));
endtask

task automatic checkMemToReg(input string name, input memToRegT expected,
                             input memToRegT actual);
  compareValue(name, 32'(expected), 32'(actual));
endtask

task automatic checkIOrD(input string name, input iOrDT expected, input iOrDT actual);
  compareValue(name, 32'(expected), 32'(actual));
endtask

task automatic checkPcSource(input string name, input pcSourceT expected,
                             input pcSourceT actual);
  compareValue(name, 32'(expected), 32'(actual));
endtask

`endif

/* testbench/tbControlUnit.sv */
`default_nettype none

module tbControlUnit;

  timeunit 1ns;
  timeprecision 100ps;

  import controlPkg::*;

  localparam int fetchWait = fetchWaitDefault;
  localparam int resetCycles = 16;
  localparam int numInstr = 18;
  localparam int cycleLimit = resetCycles + 2 + numInstr * (fetchWait + 4) + 20;

  wire clk;
  logic reset;
  opcodeT opcode;
  functT funct;
  wire pcWrite, aWrite, bWrite, epcWrite, irWrite;
  wire regWrite, memWrite, aluSrcA, resetOut;
  wire aluOpT aluOp;
  wire aluSrcBT aluSrcB;
  wire regDstT regDst;
  wire memToRegT memToReg;
  wire iOrDT iOrD;
  wire pcSourceT pcSource;

  logic expPcWrite, expAWrite, expBWrite, expEpcWrite, expIrWrite;
  logic expRegWrite, expMemWrite, expAluSrcA, expResetOut;
  aluOpT expAluOp;
  aluSrcBT expAluSrcB;
  regDstT expRegDst;
  memToRegT expMemToReg;
  iOrDT expIOrD;
  pcSourceT expPcSource;

  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  integer seed = 32'h2624;
  opcodeT legalOpcodes[5] = '{opcodeRType, opcodeAddiu, opcodeSlti, opcodeSw, opcodeJal};

  `include "controlChecks.svh"

  tbClock u_tbClock (.clk(clk));

  controlUnit #(.FetchWait(fetchWait)) u_controlUnit (.*);

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic clearExpected();
    expPcWrite = 1'b0;
    expAWrite = 1'b0;
    expBWrite = 1'b0;
    expEpcWrite = 1'b0;
    expIrWrite = 1'b0;
    expRegWrite = 1'b0;
    expMemWrite = 1'b0;
    expAluSrcA = 1'b0;
    expResetOut = 1'b0;
    expAluOp = aluPass;
    expAluSrcB = srcBReg;
    expRegDst = dstRt;
    expMemToReg = wbAluOut;
    expIOrD = addrZero;
    expPcSource = pcAlu;
  endtask

  task automatic checkOutputs();
    checkBit("pcWrite", expPcWrite, pcWrite);
    checkBit("aWrite", expAWrite, aWrite);
    checkBit("bWrite", expBWrite, bWrite);
    checkBit("epcWrite", expEpcWrite, epcWrite);
    checkBit("irWrite", expIrWrite, irWrite);
    checkBit("regWrite", expRegWrite, regWrite);
    checkBit("memWrite", expMemWrite, memWrite);
    checkBit("aluSrcA", expAluSrcA, aluSrcA);
    checkBit("resetOut", expResetOut, resetOut);
    checkAluOp("aluOp", expAluOp, aluOp);
    checkAluSrcB("aluSrcB", expAluSrcB, aluSrcB);
    checkRegDst("regDst", expRegDst, regDst);
    checkMemToReg("memToReg", expMemToReg, memToReg);
    checkIOrD("iOrD", expIOrD, iOrD);
    checkPcSource("pcSource", expPcSource, pcSource);
    if (regWrite === 1'b1 && memWrite === 1'b1) begin
      errorCount++;
      $display("regWrite and memWrite are both high at %0t", $time);
    end
  endtask

  // Check mid-cycle, then step to 1 ns after the next rising edge
  task automatic sampleAndCheck();
    @(negedge clk);
    checkOutputs();
    @(posedge clk);
    #1;
  endtask

  task automatic checkFetchWait();
    clearExpected();
    expIOrD = addrPc;
    sampleAndCheck();
  endtask

  // Register-register ALU op written back to rd
  task automatic expectRegAlu(input aluOpT op, input memToRegT wb);
    expRegWrite = 1'b1;
    expAluSrcA = 1'b1;
    expAluSrcB = srcBReg;
    expRegDst = dstRd;
    expAluOp = op;
    expMemToReg = wb;
  endtask

  // Register-immediate ALU op written back to rt
  task automatic expectImmAlu(input aluOpT op, input memToRegT wb);
    expRegWrite = 1'b1;
    expAluSrcA = 1'b1;
    expAluSrcB = srcBImm;
    expRegDst = dstRt;
    expAluOp = op;
    expMemToReg = wb;
  endtask

  task automatic expectExecute(input instrKindT kind);
    clearExpected();
    case (kind)
      kindAdd: begin
        expectRegAlu(aluAdd, wbAluOut);
      end
      kindSub: begin
        expectRegAlu(aluSub, wbAluOut);
      end
      kindAnd: begin
        expectRegAlu(aluAnd, wbAluOut);
      end
      kindSlt: begin
        expectRegAlu(aluSlt, wbLessThan);
      end
      kindAddiu: begin
        expectImmAlu(aluAdd, wbAluOut);
      end
      kindSlti: begin
        expectImmAlu(aluSlt, wbLessThan);
      end
      kindSw: begin
        expMemWrite = 1'b1;
        expAluOp = aluAdd;
        expAluSrcA = 1'b1;
        expAluSrcB = srcBImm;
        expIOrD = addrAluOut;
      end
      kindJr: begin
        expPcWrite = 1'b1;
        expAluSrcA = 1'b1;
      end
      kindJal: begin
        expPcWrite = 1'b1;
        expRegWrite = 1'b1;
        expRegDst = dstRa;
        expPcSource = pcJump;
      end
      kindBreak: begin
        expPcWrite = 1'b1;
        expAluOp = aluSub;
        expAluSrcB = srcBFour;
      end
      kindRte: begin
        expPcWrite = 1'b1;
        expPcSource = pcEpc;
      end
      default: begin
        expEpcWrite = 1'b1;
        expPcWrite = 1'b1;
        expPcSource = pcVector;
      end
    endcase
  endtask

  // Starts 1 ns after the edge that enters stFetchWait
  task automatic runInstr(input opcodeT op, input functT fn, input instrKindT kind);
    opcode = op;
    funct = fn;
    for (int i = 0; i < fetchWait; i++) begin
      checkFetchWait();
    end
    clearExpected();
    expPcWrite = 1'b1;
    expAluOp = aluAdd;
    expAluSrcB = srcBFour;
    sampleAndCheck();
    clearExpected();
    expIrWrite = 1'b1;
    sampleAndCheck();
    clearExpected();
    expAWrite = 1'b1;
    expBWrite = 1'b1;
    sampleAndCheck();
    expectExecute(kind);
    sampleAndCheck();
  endtask

  task automatic testReset();
    @(posedge clk);
    #1;
    for (int i = 0; i < resetCycles; i++) begin
      if (i == resetCycles - 1) begin
        reset = 1'b0;
      end
      clearExpected();
      expResetOut = 1'b1;
      sampleAndCheck();
    end
    // Second reset step after release
    clearExpected();
    expResetOut = 1'b1;
    sampleAndCheck();
  endtask

  task automatic testRTypeAlu();
    runInstr(opcodeRType, functAdd, kindAdd);
    runInstr(opcodeRType, functSub, kindSub);
    runInstr(opcodeRType, functAnd, kindAnd);
    runInstr(opcodeRType, functSlt, kindSlt);
  endtask

  // Funct field set to R-type codes to show it is ignored here
  task automatic testImmediate();
    runInstr(opcodeAddiu, functSlt, kindAddiu);
    runInstr(opcodeSlti, functAdd, kindSlti);
    runInstr(opcodeSw, functJr, kindSw);
  endtask

  task automatic testTransfers();
    runInstr(opcodeRType, functJr, kindJr);
    runInstr(opcodeJal, functRte, kindJal);
    runInstr(opcodeRType, functBreak, kindBreak);
    runInstr(opcodeRType, functRte, kindRte);
  endtask

  function automatic bit isLegalOpcode(input opcodeT op);
    foreach (legalOpcodes[i]) begin
      if (op == legalOpcodes[i]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic testUnknown();
    opcodeT op;
    functT fn;
    runInstr(opcodeRType, 6'b000000, kindInvalid);
    runInstr(opcodeRType, 6'b011000, kindInvalid);
    runInstr(6'b000100, functAdd, kindInvalid);
    for (int i = 0; i < 4; i++) begin
      op = opcodeT'($random(seed));
      while (isLegalOpcode(op)) begin
        op = opcodeT'($random(seed));
      end
      fn = functT'($random(seed));
      runInstr(op, fn, kindInvalid);
    end
  endtask

  initial begin
    reset = 1'b1;
    opcode = opcodeRType;
    funct = functAdd;
    testReset();
    testRTypeAlu();
    testImmediate();
    testTransfers();
    testUnknown();
    checkFetchWait();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+testbench
verilog/controlPkg.sv
verilog/instrDecoder.sv
verilog/controlFsm.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
testbench/tbClock.sv
testbench/tbControlUnit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbControlUnit
FILELIST  ?= tb.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := testbench/controlChecks.svh
BIN     := $(BUILDDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILDDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^TEST OK$$' $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)
